/* logic/interp_pkg.sv */
// Shared definitions for the stereo 2x interpolator.
// Holds the filter dimensions, the coefficient table, the sequencer and
// DSP encodings, and the packed structs that travel between the blocks.
// Modules take what they need through a wildcard import.

package interp_pkg;

    // --------------------
    // Dimensions
    // --------------------
    localparam int TAPS        = 8;
    localparam int TAP_W       = 3;
    localparam int MID_TAP     = 3;
    localparam int SAMPLE_W    = 18;
    localparam int ACC_W       = 48;
    localparam int OUT_LSB     = 16;
    localparam int DSP_LATENCY = 3;

    // Output clamp limits
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 18'sh1ffff;
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = 18'sh20000;

    // Symmetric low-pass, unity DC gain at a scale of 2^OUT_LSB
    localparam logic signed [SAMPLE_W-1:0] COEFS [TAPS] = '{
        -18'sd1966,
         18'sd4588,
         18'sd9830,
         18'sd20316,
         18'sd20316,
         18'sd9830,
         18'sd4588,
        -18'sd1966
    };

    // --------------------
    // Encodings
    // --------------------
    typedef enum logic [2:0] {
        S_WAIT_IN = 3'd0,
        S_PUSH    = 3'd1,
        S_MAC     = 3'd2,
        S_DRAIN   = 3'd3,
        S_RES_AC  = 3'd4,
        S_RES_MID = 3'd5
    } seq_state_e;

    typedef enum logic [1:0] {
        DSP_NOP      = 2'd0,
        DSP_MUL_LOAD = 2'd1,
        DSP_MUL_ACC  = 2'd2
    } dsp_op_e;

    typedef enum logic [1:0] {
        RES_NONE = 2'd0,
        RES_AC   = 2'd1,
        RES_MID  = 2'd2
    } res_sel_e;

    // --------------------
    // Structs
    // --------------------
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] left;
        logic signed [SAMPLE_W-1:0] right;
    } stereo_sample_t;

    // One lane's DSP operand set
    typedef struct packed {
        dsp_op_e                    op;
        logic signed [SAMPLE_W-1:0] coef;
        logic signed [SAMPLE_W-1:0] sample;
    } dsp_in_t;

endpackage

/* logic/interp_sequencer.sv */
// Control FSM of the interpolator.
// Steps through wait, push, MAC loop, pipeline drain and the two result
// commands for every accepted input. The repeat counter sets how long the
// MAC and drain states last; the tap counter addresses history and ROM.
// reset is the clock input, clk the asynchronous active-high clear.

`timescale 1ns/1ps

module interp_sequencer import interp_pkg::*; (
    input  logic             reset,
    input  logic             clk,
    input  logic             in_valid,
    input  logic             next_busy,
    output logic             busy,
    output logic             push,
    output logic [TAP_W-1:0] tap_idx,
    output dsp_op_e          op,
    output res_sel_e         res_sel
);

    seq_state_e       state;
    seq_state_e       state_nxt;
    logic [TAP_W-1:0] rpt_cnt;
    logic [TAP_W-1:0] tap_cnt;
    logic             rpt_last;

    // --------------------
    // Repeat control
    // --------------------
    always_comb begin
        case (state)
            S_MAC:   rpt_last = (rpt_cnt == TAP_W'(TAPS - 1));
            // One extra cycle covers the registered tap and coef reads
            S_DRAIN: rpt_last = (rpt_cnt == TAP_W'(DSP_LATENCY));
            default: rpt_last = 1'b1;
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            rpt_cnt <= '0;
        end else if (rpt_last) begin
            rpt_cnt <= '0;
        end else begin
            rpt_cnt <= rpt_cnt + 1'b1;
        end
    end

    // Tap index restarts on every push
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            tap_cnt <= '0;
        end else if (state == S_PUSH) begin
            tap_cnt <= '0;
        end else if (state == S_MAC) begin
            tap_cnt <= tap_cnt + 1'b1;
        end
    end

    // --------------------
    // State machine
    // --------------------
    always_comb begin
        state_nxt = state;
        case (state)
            S_WAIT_IN: begin
                if (in_valid) begin
                    state_nxt = S_PUSH;
                end
            end
            S_PUSH: state_nxt = S_MAC;
            S_MAC: begin
                if (rpt_last) begin
                    state_nxt = S_DRAIN;
                end
            end
            S_DRAIN: begin
                if (rpt_last) begin
                    state_nxt = S_RES_AC;
                end
            end
            S_RES_AC: begin
                if (!next_busy) begin
                    state_nxt = S_RES_MID;
                end
            end
            S_RES_MID: begin
                if (!next_busy) begin
                    state_nxt = S_WAIT_IN;
                end
            end
            default: state_nxt = S_WAIT_IN;
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state <= S_WAIT_IN;
        end else begin
            state <= state_nxt;
        end
    end

    // Task outputs decoded from the state
    always_comb begin
        busy    = (state != S_WAIT_IN);
        push    = (state == S_PUSH);
        tap_idx = tap_cnt;
        op      = DSP_NOP;
        res_sel = RES_NONE;
        if (state == S_MAC) begin
            op = (tap_cnt == '0) ? DSP_MUL_LOAD : DSP_MUL_ACC;
        end
        if (state == S_RES_AC && !next_busy) begin
            res_sel = RES_AC;
        end
        if (state == S_RES_MID && !next_busy) begin
            res_sel = RES_MID;
        end
    end

endmodule

/* logic/delay_line.sv */
// Stereo sample history for the FIR.
// A circular register array with a head pointer that steps backwards on
// each push, so tap 0 is always the newest sample. The tap read is
// registered to line up with the coefficient ROM.

`timescale 1ns/1ps

module delay_line import interp_pkg::*; (
    input  logic             reset,
    input  logic             clk,
    input  logic             push,
    input  stereo_sample_t   in_sample,
    input  logic [TAP_W-1:0] tap_idx,
    output stereo_sample_t   tap_sample,
    output stereo_sample_t   mid_sample
);

    stereo_sample_t   hist [TAPS];
    stereo_sample_t   in_reg;
    logic [TAP_W-1:0] head;
    logic [TAP_W-1:0] wr_ptr;
    logic [TAP_W-1:0] rd_ptr;
    logic [TAP_W-1:0] mid_ptr;

    // Pointer arithmetic wraps modulo TAPS
    assign wr_ptr  = head - 1'b1;
    assign rd_ptr  = head + tap_idx;
    assign mid_ptr = head + TAP_W'(MID_TAP);

    // Sample seen on the accept edge is held through the push cycle
    always_ff @(posedge reset) begin
        in_reg <= in_sample;
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            head <= '0;
            for (int i = 0; i < TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (push) begin
            hist[wr_ptr] <= in_reg;
            head         <= wr_ptr;
        end
    end

    always_ff @(posedge reset) begin
        tap_sample <= hist[rd_ptr];
    end

    assign mid_sample = hist[mid_ptr];

endmodule

/* logic/coef_rom.sv */
// Coefficient lookup for the FIR taps.
// Reads the fixed table from the package at the tap index and registers
// it, so the coefficient arrives in the same cycle as the tap sample.

`timescale 1ns/1ps

module coef_rom import interp_pkg::*; (
    input  logic                       reset,
    input  logic                       clk,
    input  logic [TAP_W-1:0]           tap_idx,
    output logic signed [SAMPLE_W-1:0] coef
);

    logic signed [SAMPLE_W-1:0] coef_lookup;

    assign coef_lookup = COEFS[tap_idx];

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            coef <= '0;
        end else begin
            coef <= coef_lookup;
        end
    end

endmodule

/* logic/mac_lane.sv */
// Multiply-accumulate lane for one audio channel.
// Models a DSP slice with three stages: operand register, product
// register carrying the op, and the 48-bit accumulator. LOAD replaces
// the accumulator, ACC adds to it, NOP holds it.

`timescale 1ns/1ps

module mac_lane import interp_pkg::*; (
    input  logic                    reset,
    input  logic                    clk,
    input  dsp_in_t                 dsp_in,
    output logic signed [ACC_W-1:0] acc
);

    dsp_op_e                      in_op;
    logic signed [SAMPLE_W-1:0]   in_coef;
    logic signed [SAMPLE_W-1:0]   in_sample;
    dsp_op_e                      prod_op;
    logic signed [2*SAMPLE_W-1:0] prod;
    logic signed [ACC_W-1:0]      prod_ext;

    // Op moves along with the operand stages
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            in_op   <= DSP_NOP;
            prod_op <= DSP_NOP;
        end else begin
            in_op   <= dsp_in.op;
            prod_op <= in_op;
        end
    end

    always_ff @(posedge reset) begin
        in_coef   <= dsp_in.coef;
        in_sample <= dsp_in.sample;
        prod      <= in_coef * in_sample;
    end

    assign prod_ext = {{(ACC_W - 2*SAMPLE_W){prod[2*SAMPLE_W-1]}}, prod};

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            acc <= '0;
        end else begin
            case (prod_op)
                DSP_MUL_LOAD: acc <= prod_ext;
                DSP_MUL_ACC:  acc <= acc + prod_ext;
                default:      acc <= acc;
            endcase
        end
    end

endmodule

/* logic/result_stage.sv */
// Output stage of the interpolator.
// On RES_AC it scales both accumulators down by OUT_LSB and clamps them
// to the 18-bit range; on RES_MID it halves the middle tap. The result is
// registered with a one-cycle valid pulse and held until the next one.

`timescale 1ns/1ps

module result_stage import interp_pkg::*; (
    input  logic                    reset,
    input  logic                    clk,
    input  res_sel_e                res_sel,
    input  logic signed [ACC_W-1:0] acc_l,
    input  logic signed [ACC_W-1:0] acc_r,
    input  stereo_sample_t          mid_sample,
    output logic                    out_valid,
    output stereo_sample_t          out_sample
);

    logic signed [SAMPLE_W-1:0] mid_l;
    logic signed [SAMPLE_W-1:0] mid_r;

    // Truncating scale, then clamp
    function automatic logic signed [SAMPLE_W-1:0] sat_acc(
        input logic signed [ACC_W-1:0] a
    );
        logic signed [ACC_W-1:0] s;
        s = a >>> OUT_LSB;
        if (s > SAMPLE_MAX) begin
            return SAMPLE_MAX;
        end else if (s < SAMPLE_MIN) begin
            return SAMPLE_MIN;
        end
        return s[SAMPLE_W-1:0];
    endfunction

    assign mid_l = mid_sample.left;
    assign mid_r = mid_sample.right;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= (res_sel != RES_NONE);
        end
    end

    always_ff @(posedge reset) begin
        if (res_sel == RES_AC) begin
            out_sample.left  <= sat_acc(acc_l);
            out_sample.right <= sat_acc(acc_r);
        end else if (res_sel == RES_MID) begin
            out_sample.left  <= mid_l >>> 1;
            out_sample.right <= mid_r >>> 1;
        end
    end

endmodule

/* logic/interpolator_2x_top.sv */
// Top level of the stereo 2x half-band interpolator.
// Connects the sequencer, the sample history, the coefficient ROM, one
// MAC lane per channel and the result stage. The op is delayed here by
// one cycle to meet the registered tap and coefficient reads.

`timescale 1ns/1ps

module interpolator_2x_top import interp_pkg::*; (
    input  logic           reset,
    input  logic           clk,
    input  logic           in_valid,
    input  stereo_sample_t in_sample,
    input  logic           next_busy,
    output logic           busy,
    output logic           out_valid,
    output stereo_sample_t out_sample
);

    logic                       push;
    logic [TAP_W-1:0]           tap_idx;
    dsp_op_e                    op;
    dsp_op_e                    op_d;
    res_sel_e                   res_sel;
    stereo_sample_t             tap_sample;
    stereo_sample_t             mid_sample;
    logic signed [SAMPLE_W-1:0] coef;
    dsp_in_t                    dsp_in_l;
    dsp_in_t                    dsp_in_r;
    logic signed [ACC_W-1:0]    acc_l;
    logic signed [ACC_W-1:0]    acc_r;

    interp_sequencer u_interp_sequencer (
        .reset     (reset),
        .clk       (clk),
        .in_valid  (in_valid),
        .next_busy (next_busy),
        .busy      (busy),
        .push      (push),
        .tap_idx   (tap_idx),
        .op        (op),
        .res_sel   (res_sel)
    );

    delay_line u_delay_line (
        .reset      (reset),
        .clk        (clk),
        .push       (push),
        .in_sample  (in_sample),
        .tap_idx    (tap_idx),
        .tap_sample (tap_sample),
        .mid_sample (mid_sample)
    );

    coef_rom u_coef_rom (
        .reset   (reset),
        .clk     (clk),
        .tap_idx (tap_idx),
        .coef    (coef)
    );

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op_d <= DSP_NOP;
        end else begin
            op_d <= op;
        end
    end

    assign dsp_in_l = '{op: op_d, coef: coef, sample: tap_sample.left};
    assign dsp_in_r = '{op: op_d, coef: coef, sample: tap_sample.right};

    mac_lane u_mac_l (
        .reset  (reset),
        .clk    (clk),
        .dsp_in (dsp_in_l),
        .acc    (acc_l)
    );

    mac_lane u_mac_r (
        .reset  (reset),
        .clk    (clk),
        .dsp_in (dsp_in_r),
        .acc    (acc_r)
    );

    result_stage u_result_stage (
        .reset      (reset),
        .clk        (clk),
        .res_sel    (res_sel),
        .acc_l      (acc_l),
        .acc_r      (acc_r),
        .mid_sample (mid_sample),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

endmodule

/* dv/interp_assert.sv */
// Handshake checks for the interpolator top level, attached by bind.
// Covers the sink's next_busy rule, busy after an accept, and busy
// holding until both outputs of an input have left.

`timescale 1ns/1ps

module interp_assert (
    input logic reset,
    input logic clk,
    input logic in_valid,
    input logic next_busy,
    input logic busy,
    input logic out_valid
);

    // Outputs still owed for the input in flight
    logic [1:0] pend;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pend <= '0;
        end else if (in_valid && !busy) begin
            pend <= 2'd2;
        end else if (out_valid) begin
            pend <= pend - 2'd1;
        end
    end

    // next_busy announces the sink state for the following cycle
    a_out_vs_next_busy: assert property (@(posedge reset) disable iff (clk)
        out_valid |-> !$past(next_busy))
        else $error("out_valid high in a cycle the sink had announced as busy");

    a_busy_after_accept: assert property (@(posedge reset) disable iff (clk)
        (in_valid && !busy) |=> busy)
        else $error("busy did not rise after an accepted input");

    a_busy_until_done: assert property (@(posedge reset) disable iff (clk)
        !busy |-> (pend == {1'b0, out_valid}))
        else $error("busy dropped before both outputs of the input were sent");

endmodule

bind interpolator_2x_top interp_assert u_interp_assert (.*);

/* dv/interp_tb.sv */
// Testbench for the stereo 2x interpolator.
// Runs an idle check, an impulse, a random stream, saturation runs and a
// back-pressured stream. A reference model follows every accepted input,
// and the scoreboard compares each output pulse in order.

`timescale 1ns/1ps

module interp_tb import interp_pkg::*; ();

    localparam int PERIOD    = 100;
    localparam int MAX_BP    = 24;
    localparam int N_RANDOM  = 120;
    localparam int N_BP      = 80;
    localparam int N_SAMPLES = 1 + TAPS + N_RANDOM + 2 * TAPS + N_BP;

    logic           reset;
    logic           clk;
    logic           in_valid;
    logic           next_busy;
    logic           busy;
    logic           out_valid;
    stereo_sample_t in_sample;
    stereo_sample_t out_sample;

    stereo_sample_t mhist [TAPS];
    stereo_sample_t exp_q [$];
    integer         seed = 32'h4f85_f3c9;
    int             bp_run;

    interpolator_2x_top u_interpolator_2x_top (
        .reset      (reset),
        .clk        (clk),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .next_busy  (next_busy),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

    initial begin
        reset = 1'b0;
        forever #(PERIOD / 2) reset = ~reset;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    initial begin
        #(longint'(N_SAMPLES * (30 + MAX_BP) + 100) * PERIOD);
        abort_run("Watchdog expired: outputs stopped arriving from the DUT");
    end

    // --------------------
    // Reference model
    // --------------------
    function automatic stereo_sample_t pack_sample(input logic signed [SAMPLE_W-1:0] l,
                                                   input logic signed [SAMPLE_W-1:0] r);
        stereo_sample_t s;
        s.left  = l;
        s.right = r;
        return s;
    endfunction

    function automatic logic signed [SAMPLE_W-1:0] clamp_sum(input longint s);
        longint t;
        t = s >>> OUT_LSB;
        if (t > longint'(SAMPLE_MAX)) return SAMPLE_MAX;
        if (t < longint'(SAMPLE_MIN)) return SAMPLE_MIN;
        return t[SAMPLE_W-1:0];
    endfunction

    // Newest sample sits at index 0, as in the DUT history
    task automatic model_push(input stereo_sample_t d);
        longint         sl;
        longint         sr;
        stereo_sample_t e;
        for (int k = TAPS - 1; k > 0; k--) begin
            mhist[k] = mhist[k-1];
        end
        mhist[0] = d;
        sl = 0;
        sr = 0;
        for (int k = 0; k < TAPS; k++) begin
            sl += longint'(COEFS[k]) * longint'(mhist[k].left);
            sr += longint'(COEFS[k]) * longint'(mhist[k].right);
        end
        e.left  = clamp_sum(sl);
        e.right = clamp_sum(sr);
        exp_q.push_back(e);
        e.left  = mhist[MID_TAP].left >>> 1;
        e.right = mhist[MID_TAP].right >>> 1;
        exp_q.push_back(e);
    endtask

    // --------------------
    // Stimulus and scoreboard
    // --------------------
    function automatic stereo_sample_t rand_sample();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[35:0];
    endfunction

    // Short random busy cycles plus occasional long runs up to MAX_BP
    function automatic logic pick_next_busy(input logic bp);
        logic [31:0] r;
        if (!bp) return 1'b0;
        if (bp_run > 0) begin
            bp_run--;
            return 1'b1;
        end
        r = $random(seed);
        if (r[2:0] == 3'd0) begin
            bp_run = int'(r[11:8]) + (r[12] ? 8 : 0);
            return 1'b1;
        end
        return r[13] & r[14];
    endfunction

    task automatic report_mismatch(input string name, input logic signed [SAMPLE_W-1:0] got,
                                   input logic signed [SAMPLE_W-1:0] want);
        abort_run($sformatf("Mismatch at %0t: %s got %0d, expected %0d",
                            $time, name, got, want));
    endtask

    task automatic check_output();
        stereo_sample_t want;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("out_valid pulsed with no expected output pending");
            end else begin
                want = exp_q.pop_front();
                assert (out_sample.left == want.left)
                    else report_mismatch("out_sample.left", out_sample.left, want.left);
                assert (out_sample.right == want.right)
                    else report_mismatch("out_sample.right", out_sample.right, want.right);
            end
        end
    endtask

    // Junk is offered while busy, the real sample once busy is low
    task automatic send(input stereo_sample_t d, input logic bp);
        logic           taken;
        stereo_sample_t junk;
        taken = 1'b0;
        while (!taken) begin
            @(negedge reset);
            check_output();
            next_busy = pick_next_busy(bp);
            if (!busy) begin
                model_push(d);
                in_valid  = 1'b1;
                in_sample = d;
                taken     = 1'b1;
            end else begin
                junk      = rand_sample();
                in_valid  = junk.left[0];
                in_sample = junk;
            end
        end
    endtask

    task automatic drain(input logic bp);
        while (exp_q.size() != 0) begin
            @(negedge reset);
            check_output();
            next_busy = pick_next_busy(bp);
            in_valid  = 1'b0;
        end
    endtask

    initial begin
        logic pos;
        clk       = 1'b1;
        in_valid  = 1'b0;
        in_sample = '0;
        next_busy = 1'b0;
        bp_run    = 0;
        for (int k = 0; k < TAPS; k++) begin
            mhist[k] = '0;
        end
        repeat (8) @(posedge reset);
        @(negedge reset);
        clk = 1'b0;

        repeat (10) begin
            @(negedge reset);
            assert (!busy && !out_valid)
                else abort_run("busy or out_valid went high before any input was offered");
        end

        // Impulse on the left channel only
        send(pack_sample(SAMPLE_MAX, '0), 1'b0);
        repeat (TAPS) send(pack_sample('0, '0), 1'b0);

        repeat (N_RANDOM) send(rand_sample(), 1'b0);

        // Signs follow the coefficient signs so the sums overshoot
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < TAPS; k++) begin
                pos = (k != 0 && k != TAPS - 1) ^ (p == 1);
                send(pos ? pack_sample(SAMPLE_MAX, SAMPLE_MIN)
                         : pack_sample(SAMPLE_MIN, SAMPLE_MAX), 1'b0);
            end
        end

        repeat (N_BP) send(rand_sample(), 1'b1);
        drain(1'b1);

        // Quiet tail, no further output may appear
        next_busy = 1'b0;
        repeat (2 * TAPS) begin
            @(negedge reset);
            check_output();
        end

        if (!busy) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("DUT still busy at the end of the run");
        end
    end

endmodule

/* filelist.f */
logic/interp_pkg.sv
logic/interp_sequencer.sv
logic/delay_line.sv
logic/coef_rom.sv
logic/mac_lane.sv
logic/result_stage.sv
logic/interpolator_2x_top.sv
dv/interp_assert.sv
dv/interp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the interpolator testbench with Verilator.
# The exit status is the simulator's, nonzero on any failure.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module interp_tb -f filelist.f -o interp_sim

./obj_dir/interp_sim
